// ==== source/lpif_link_pkg.sv ====
// LPIF logic link shared layout
// Flit field offsets, PHY lane geometry and delay counter width

package lpif_link_pkg;

  ////////////////////
  // Flit layout

  // Packed flit width
  localparam int flit_w = 141;

  // Field widths
  localparam int valid_w     = 1;
  localparam int crc_valid_w = 1;
  localparam int crc_w       = 4;
  localparam int dvalid_w    = 1;
  localparam int data_w      = 128;
  localparam int protid_w    = 2;
  localparam int state_w     = 4;

  // Field offsets, LSB first
  localparam int valid_off     = 0;
  localparam int crc_valid_off = 1;
  localparam int crc_off       = 2;
  localparam int dvalid_off    = 6;
  localparam int data_off      = 7;
  localparam int protid_off    = 135;
  localparam int state_off     = 137;

  ////////////////////
  // PHY lanes

  localparam int lane_cnt   = 4;
  localparam int lane_w     = 40;
  // Bit 0 strobe, bit 1 marker, bits 39:2 payload
  localparam int lane_pay_w = 38;
  // Payload capacity of all lanes, upper bits padded
  localparam int stripe_w   = lane_cnt * lane_pay_w;

  // Online delay counters
  localparam int delay_w = 16;

endpackage

// ==== source/lpif_online_sync.sv ====
// Online delay control
// Holds tx and rx online back until the input has been seen high
// for the programmed number of consecutive cycles

module lpif_online_sync (
  input  logic                              clk_wr,
  input  logic                              rst_n,

  // Raw online requests
  input  logic                              tx_online,
  input  logic                              rx_online,

  // Programmed delays
  input  logic [lpif_link_pkg::delay_w-1:0] delay_x_value,
  input  logic [lpif_link_pkg::delay_w-1:0] delay_y_value,

  // Delayed online
  output logic                              tx_online_delay,
  output logic                              rx_online_delay
);

  import lpif_link_pkg::*;

  ////////////////////
  // Channel arrays

  // Channel 0 is tx, channel 1 is rx
  logic               online    [2];
  logic [delay_w-1:0] delay_val [2];
  logic [delay_w-1:0] cnt_q     [2];
  logic               online_q  [2];

  // Tx uses delay_y, rx uses delay_x (word alignment)
  assign online[0]    = tx_online;
  assign online[1]    = rx_online;
  assign delay_val[0] = delay_y_value;
  assign delay_val[1] = delay_x_value;

  ////////////////////
  // Saturating counters

  always_ff @(posedge clk_wr) begin
    logic [delay_w:0] cnt_inc;
    if (!rst_n) begin
      for (int ch = 0; ch < 2; ch++) begin
        cnt_q[ch]    <= '0;
        online_q[ch] <= 1'b0;
      end
    end else begin
      for (int ch = 0; ch < 2; ch++) begin
        // High samples seen including this edge
        cnt_inc = {1'b0, cnt_q[ch]} + 1'b1;
        if (!online[ch]) begin
          // Offline clears count and output at once
          cnt_q[ch]    <= '0;
          online_q[ch] <= 1'b0;
        end else begin
          // Hold at all ones
          if (!cnt_inc[delay_w])
            cnt_q[ch] <= cnt_inc[delay_w-1:0];
          // Delay 0 behaves like delay 1
          online_q[ch] <= (cnt_inc >= {1'b0, delay_val[ch]});
        end
      end
    end
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  ////////////////////
  // Checks

  // Delayed tx online drops one edge after request goes low
  a_tx_offline_drop : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    !tx_online |=> !tx_online_delay
  ) else $error("tx_online_delay high after tx_online sampled low");

endmodule

// ==== source/lpif_flit_map.sv ====
// Flit field mapping
// Packs downstream fields into a transmit flit and unpacks
// qualified receive flits onto registered upstream fields

module lpif_flit_map (
  input  logic                               clk_wr,
  input  logic                               rst_n,

  // Downstream fields
  input  logic [lpif_link_pkg::state_w-1:0]  dstrm_state,
  input  logic [lpif_link_pkg::protid_w-1:0] dstrm_protid,
  input  logic [lpif_link_pkg::data_w-1:0]   dstrm_data,
  input  logic                               dstrm_dvalid,
  input  logic [lpif_link_pkg::crc_w-1:0]    dstrm_crc,
  input  logic                               dstrm_crc_valid,
  input  logic                               dstrm_valid,

  // Flit to lane striping
  output logic [lpif_link_pkg::flit_w-1:0]   tx_flit,

  // Flit from lane gathering
  input  logic [lpif_link_pkg::flit_w-1:0]   rx_flit,
  input  logic                               rx_flit_ok,

  // Upstream fields
  output logic [lpif_link_pkg::state_w-1:0]  ustrm_state,
  output logic [lpif_link_pkg::protid_w-1:0] ustrm_protid,
  output logic [lpif_link_pkg::data_w-1:0]   ustrm_data,
  output logic                               ustrm_dvalid,
  output logic [lpif_link_pkg::crc_w-1:0]    ustrm_crc,
  output logic                               ustrm_crc_valid,
  output logic                               ustrm_valid
);

  import lpif_link_pkg::*;

  ////////////////////
  // Transmit pack

  // Fields tile the flit with no gaps
  always_comb begin
    tx_flit                                = '0;
    tx_flit[valid_off     +: valid_w]      = dstrm_valid;
    tx_flit[crc_valid_off +: crc_valid_w]  = dstrm_crc_valid;
    tx_flit[crc_off       +: crc_w]        = dstrm_crc;
    tx_flit[dvalid_off    +: dvalid_w]     = dstrm_dvalid;
    tx_flit[data_off      +: data_w]       = dstrm_data;
    tx_flit[protid_off    +: protid_w]     = dstrm_protid;
    tx_flit[state_off     +: state_w]      = dstrm_state;
  end

  ////////////////////
  // Receive unpack

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !rx_flit_ok) begin
      // Bad strobes or offline give an all zero flit
      ustrm_state     <= '0;
      ustrm_protid    <= '0;
      ustrm_data      <= '0;
      ustrm_dvalid    <= 1'b0;
      ustrm_crc       <= '0;
      ustrm_crc_valid <= 1'b0;
      ustrm_valid     <= 1'b0;
    end else begin
      ustrm_state     <= rx_flit[state_off     +: state_w];
      ustrm_protid    <= rx_flit[protid_off    +: protid_w];
      ustrm_data      <= rx_flit[data_off      +: data_w];
      ustrm_dvalid    <= rx_flit[dvalid_off    +: dvalid_w];
      ustrm_crc       <= rx_flit[crc_off       +: crc_w];
      ustrm_crc_valid <= rx_flit[crc_valid_off +: crc_valid_w];
      ustrm_valid     <= rx_flit[valid_off     +: valid_w];
    end
  end

  // Far end must only send data valid inside a valid flit
  a_dvalid_needs_valid : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    $rose(ustrm_dvalid) |-> ustrm_valid
  ) else $error("ustrm_dvalid rose without ustrm_valid");

endmodule

// ==== source/lpif_lane_stripe.sv ====
// Lane striping for a four lane PHY
// Spreads each flit over the lane payloads with a persistent strobe,
// then gathers received lanes and qualifies them by strobe and online

module lpif_lane_stripe (
  input  logic                                  clk_wr,
  input  logic                                  rst_n,

  // Delayed online
  input  logic                                  tx_online_delay,
  input  logic                                  rx_online_delay,

  // Transmit flit
  input  logic [lpif_link_pkg::flit_w-1:0]      tx_flit,

  // PHY transmit lanes
  output logic [lpif_link_pkg::lane_w-1:0]      tx_phy0,
  output logic [lpif_link_pkg::lane_w-1:0]      tx_phy1,
  output logic [lpif_link_pkg::lane_w-1:0]      tx_phy2,
  output logic [lpif_link_pkg::lane_w-1:0]      tx_phy3,

  // PHY receive lanes
  input  logic [lpif_link_pkg::lane_w-1:0]      rx_phy0,
  input  logic [lpif_link_pkg::lane_w-1:0]      rx_phy1,
  input  logic [lpif_link_pkg::lane_w-1:0]      rx_phy2,
  input  logic [lpif_link_pkg::lane_w-1:0]      rx_phy3,

  // Received flit and its qualifier
  output logic [lpif_link_pkg::flit_w-1:0]      rx_flit,
  output logic                                  rx_flit_ok
);

  import lpif_link_pkg::*;

  ////////////////////
  // Transmit striping

  logic [stripe_w-1:0] tx_stripe;
  logic [lane_w-1:0]   tx_lane_d [lane_cnt];
  logic [lane_w-1:0]   tx_lane_q [lane_cnt];

  // Zero pad above the flit
  assign tx_stripe = {{(stripe_w - flit_w){1'b0}}, tx_flit};

  always_comb begin
    for (int ln = 0; ln < lane_cnt; ln++) begin
      // Payload on 39:2, marker unused, strobe persistent
      tx_lane_d[ln] = {tx_stripe[ln*lane_pay_w +: lane_pay_w], 1'b0, 1'b1};
    end
  end

  // Lanes idle at zero until tx online delay expires
  always_ff @(posedge clk_wr) begin
    for (int ln = 0; ln < lane_cnt; ln++) begin
      if (!rst_n || !tx_online_delay)
        tx_lane_q[ln] <= '0;
      else
        tx_lane_q[ln] <= tx_lane_d[ln];
    end
  end

  assign tx_phy0 = tx_lane_q[0];
  assign tx_phy1 = tx_lane_q[1];
  assign tx_phy2 = tx_lane_q[2];
  assign tx_phy3 = tx_lane_q[3];

  ////////////////////
  // Receive gathering

  logic [lane_w-1:0]   rx_lane [lane_cnt];
  logic [lane_cnt-1:0] rx_stb;
  logic [flit_w-1:0]   rx_flit_d;

  assign rx_lane[0] = rx_phy0;
  assign rx_lane[1] = rx_phy1;
  assign rx_lane[2] = rx_phy2;
  assign rx_lane[3] = rx_phy3;

  always_comb begin
    for (int ln = 0; ln < lane_cnt; ln++)
      rx_stb[ln] = rx_lane[ln][0];
    // Flit bit b sits in lane b/38 at payload position b%38
    for (int b = 0; b < flit_w; b++)
      rx_flit_d[b] = rx_lane[b / lane_pay_w][2 + (b % lane_pay_w)];
  end

  // Gathered payload, qualified by rx_flit_ok
  always_ff @(posedge clk_wr) begin
    rx_flit <= rx_flit_d;
  end

  // Qualifier needs every strobe and rx online
  always_ff @(posedge clk_wr) begin
    if (!rst_n)
      rx_flit_ok <= 1'b0;
    else
      rx_flit_ok <= (&rx_stb) && rx_online_delay;
  end

  // Mixed strobes point at a lane fault or skew
  a_rx_stb_agree : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    rx_online_delay |-> (rx_stb == '0 || rx_stb == '1)
  ) else $warning("rx strobes disagree across lanes: %b", rx_stb);

endmodule

// ==== source/lpif_link_top.sv ====
// LPIF logic link top level
// One flit per cycle over four 40 bit PHY lanes, with
// delayed online control for word alignment

module lpif_link_top (
  input  logic                               clk_wr,
  input  logic                               rst_n,

  // Control
  input  logic                               tx_online,
  input  logic                               rx_online,
  input  logic [lpif_link_pkg::delay_w-1:0]  delay_x_value,
  input  logic [lpif_link_pkg::delay_w-1:0]  delay_y_value,

  // PHY lanes
  output logic [lpif_link_pkg::lane_w-1:0]   tx_phy0,
  output logic [lpif_link_pkg::lane_w-1:0]   tx_phy1,
  output logic [lpif_link_pkg::lane_w-1:0]   tx_phy2,
  output logic [lpif_link_pkg::lane_w-1:0]   tx_phy3,
  input  logic [lpif_link_pkg::lane_w-1:0]   rx_phy0,
  input  logic [lpif_link_pkg::lane_w-1:0]   rx_phy1,
  input  logic [lpif_link_pkg::lane_w-1:0]   rx_phy2,
  input  logic [lpif_link_pkg::lane_w-1:0]   rx_phy3,

  // Downstream channel
  input  logic [lpif_link_pkg::state_w-1:0]  dstrm_state,
  input  logic [lpif_link_pkg::protid_w-1:0] dstrm_protid,
  input  logic [lpif_link_pkg::data_w-1:0]   dstrm_data,
  input  logic                               dstrm_dvalid,
  input  logic [lpif_link_pkg::crc_w-1:0]    dstrm_crc,
  input  logic                               dstrm_crc_valid,
  input  logic                               dstrm_valid,

  // Upstream channel
  output logic [lpif_link_pkg::state_w-1:0]  ustrm_state,
  output logic [lpif_link_pkg::protid_w-1:0] ustrm_protid,
  output logic [lpif_link_pkg::data_w-1:0]   ustrm_data,
  output logic                               ustrm_dvalid,
  output logic [lpif_link_pkg::crc_w-1:0]    ustrm_crc,
  output logic                               ustrm_crc_valid,
  output logic                               ustrm_valid
);

  import lpif_link_pkg::*;

  ////////////////////
  // Internal wires

  logic              tx_online_delay;
  logic              rx_online_delay;
  logic [flit_w-1:0] tx_flit;
  logic [flit_w-1:0] rx_flit;
  logic              rx_flit_ok;

  ////////////////////
  // Online control

  lpif_online_sync i_lpif_online_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  ////////////////////
  // Field mapping

  lpif_flit_map i_lpif_flit_map (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .rx_flit_ok      (rx_flit_ok),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  ////////////////////
  // Lane striping

  lpif_lane_stripe i_lpif_lane_stripe (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_flit         (tx_flit),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .tx_phy2         (tx_phy2),
    .tx_phy3         (tx_phy3),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .rx_phy2         (rx_phy2),
    .rx_phy3         (rx_phy3),
    .rx_flit         (rx_flit),
    .rx_flit_ok      (rx_flit_ok)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
// Clock and reset source for the link testbench
// 100 unit clock period, reset held low for three cycles

module tb_clock_gen (
  output logic clk_wr,
  output logic rst_n
);

  initial begin
    clk_wr = 1'b0;
    forever #50 clk_wr = ~clk_wr;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk_wr);
    @(negedge clk_wr);
    rst_n = 1'b1;
  end

endmodule

// ==== tb/lpif_link_tb.sv ====
// Testbench for the LPIF logic link
// Table driven stimulus over a TX to RX lane loopback, checked
// against a three stage model of the link pipeline

module lpif_link_tb;

  import lpif_link_pkg::*;

  localparam int          n_rows    = 10;
  localparam int          max_delay = 5;
  localparam logic [31:0] seed      = 32'h51cc_d64a;

  typedef struct packed {
    logic               tx_on;
    logic               rx_on;
    logic               corrupt;
    logic [delay_w-1:0] dx;
    logic [delay_w-1:0] dy;
    logic [7:0]         cycles;
    logic [state_w-1:0] state;
    logic [protid_w-1:0] protid;
    logic               dvalid;
    logic [crc_w-1:0]   crc;
    logic               crc_valid;
    logic               valid;
  } row_t;

  logic                clk_wr, rst_n, tx_online, rx_online;
  logic [delay_w-1:0]  delay_x_value, delay_y_value;
  logic [state_w-1:0]  dstrm_state, ustrm_state;
  logic [protid_w-1:0] dstrm_protid, ustrm_protid;
  logic [data_w-1:0]   dstrm_data, ustrm_data;
  logic [crc_w-1:0]    dstrm_crc, ustrm_crc;
  logic                dstrm_dvalid, dstrm_crc_valid, dstrm_valid;
  logic                ustrm_dvalid, ustrm_crc_valid, ustrm_valid;
  logic [lane_w-1:0]   tx_phy0, tx_phy1, tx_phy2, tx_phy3;
  logic [lane_w-1:0]   rx_phy0, rx_phy1, rx_phy2, rx_phy3;

  // Table override of the receive lanes
  logic                use_drv;
  logic [lane_w-1:0]   rx_drv [lane_cnt];

  string row_name [n_rows];
  row_t  row_tab  [n_rows];
  int    n_added, limit, cycle_cnt;
  logic [31:0] rng;

  // Reference model, one entry per register stage
  logic [lane_w-1:0] m_tx_phy [lane_cnt];
  logic [flit_w-1:0] m_rx_flit, m_ustrm, cur_flit;
  logic              m_rx_ok, m_tx_od, m_rx_od;
  int                m_tx_run, m_rx_run;

  tb_clock_gen i_tb_clock_gen (.clk_wr(clk_wr), .rst_n(rst_n));

  lpif_link_top i_lpif_link_top (.*);

  // External loopback unless the row breaks the strobes
  assign rx_phy0 = use_drv ? rx_drv[0] : tx_phy0;
  assign rx_phy1 = use_drv ? rx_drv[1] : tx_phy1;
  assign rx_phy2 = use_drv ? rx_drv[2] : tx_phy2;
  assign rx_phy3 = use_drv ? rx_drv[3] : tx_phy3;

  ////////////////////
  // Helpers

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Lane l as sent, payload 38 bits up from the flit LSB
  function automatic logic [lane_w-1:0] lane_of(input logic [flit_w-1:0] f, input int l);
    logic [stripe_w-1:0] padded;
    padded = stripe_w'(f);
    return {padded[l*lane_pay_w +: lane_pay_w], 2'b01};
  endfunction

  function automatic logic [flit_w-1:0] gather(input logic [lane_w-1:0] ln [lane_cnt]);
    logic [stripe_w-1:0] s;
    s = {ln[3][39:2], ln[2][39:2], ln[1][39:2], ln[0][39:2]};
    return s[flit_w-1:0];
  endfunction

  task automatic add_row(input string name, input bit tx_on, input bit rx_on,
                         input bit corrupt, input int dx, input int dy, input int cycles,
                         input bit [3:0] st, input bit [1:0] pid, input bit dv,
                         input bit [3:0] crc, input bit cv, input bit v);
    row_name[n_added] = name;
    row_tab[n_added]  = '{tx_on, rx_on, corrupt, 16'(dx), 16'(dy), 8'(cycles),
                          st, pid, dv, crc, cv, v};
    n_added++;
  endtask

  task automatic check_value(input string what, input logic [127:0] exp,
                             input logic [127:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", what, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Falling edge drive of one table cycle
  task automatic drive_row(input int r, input int c);
    row_t rw;
    rw              = row_tab[r];
    tx_online       = rw.tx_on;
    rx_online       = rw.rx_on;
    delay_x_value   = rw.dx;
    delay_y_value   = rw.dy;
    use_drv         = rw.corrupt;
    dstrm_state     = rw.state;
    dstrm_protid    = rw.protid;
    dstrm_dvalid    = rw.dvalid;
    dstrm_crc       = rw.crc;
    dstrm_crc_valid = rw.crc_valid;
    dstrm_valid     = rw.valid;
    for (int w = 0; w < 4; w++) begin
      rng = xorshift(rng);
      dstrm_data[w*32 +: 32] = rng;
    end
    cur_flit = {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                dstrm_crc, dstrm_crc_valid, dstrm_valid};
    // Good payload, one strobe dropped, rotating lane
    for (int l = 0; l < lane_cnt; l++)
      rx_drv[l] = lane_of(cur_flit, l);
    rx_drv[c % lane_cnt][0] = 1'b0;
  endtask

  // Later stages first so each uses the pre-edge values
  task automatic step_model();
    logic [lane_w-1:0] rx_in [lane_cnt];
    m_ustrm = m_rx_ok ? m_rx_flit : '0;
    for (int l = 0; l < lane_cnt; l++)
      rx_in[l] = use_drv ? rx_drv[l] : m_tx_phy[l];
    m_rx_flit = gather(rx_in);
    m_rx_ok   = rx_in[0][0] & rx_in[1][0] & rx_in[2][0] & rx_in[3][0] & m_rx_od;
    for (int l = 0; l < lane_cnt; l++)
      m_tx_phy[l] = m_tx_od ? lane_of(cur_flit, l) : '0;
    // Run of consecutive high samples against the delay
    m_tx_run = tx_online ? m_tx_run + 1 : 0;
    m_rx_run = rx_online ? m_rx_run + 1 : 0;
    m_tx_od  = tx_online && (m_tx_run >= int'(delay_y_value));
    m_rx_od  = rx_online && (m_rx_run >= int'(delay_x_value));
  endtask

  task automatic check_outputs(input string name);
    logic [state_w-1:0]  e_state;
    logic [protid_w-1:0] e_protid;
    logic [data_w-1:0]   e_data;
    logic [crc_w-1:0]    e_crc;
    logic                e_dvalid, e_crc_valid, e_valid;
    {e_state, e_protid, e_data, e_dvalid, e_crc, e_crc_valid, e_valid} = m_ustrm;
    check_value({name, " tx_phy0"}, m_tx_phy[0], tx_phy0);
    check_value({name, " tx_phy1"}, m_tx_phy[1], tx_phy1);
    check_value({name, " tx_phy2"}, m_tx_phy[2], tx_phy2);
    check_value({name, " tx_phy3"}, m_tx_phy[3], tx_phy3);
    // Markers and lane 3 padding above flit bit 140
    check_value({name, " markers"}, 0, {tx_phy3[1], tx_phy2[1], tx_phy1[1], tx_phy0[1]});
    check_value({name, " padding"}, 0, tx_phy3[39:29]);
    check_value({name, " ustrm_state"}, e_state, ustrm_state);
    check_value({name, " ustrm_protid"}, e_protid, ustrm_protid);
    check_value({name, " ustrm_data"}, e_data, ustrm_data);
    check_value({name, " ustrm_dvalid"}, e_dvalid, ustrm_dvalid);
    check_value({name, " ustrm_crc"}, e_crc, ustrm_crc);
    check_value({name, " ustrm_crc_valid"}, e_crc_valid, ustrm_crc_valid);
    check_value({name, " ustrm_valid"}, e_valid, ustrm_valid);
  endtask

  ////////////////////
  // Watchdog

  always @(posedge clk_wr) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= limit) begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "Timeout, table not finished after %0d cycles", cycle_cnt);
    end
  end

  ////////////////////
  // Main sequence

  initial begin
    rng = seed;
    n_added = 0;
    cycle_cnt = 0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    delay_x_value = '0;
    delay_y_value = '0;
    {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid} = '0;
    {dstrm_crc, dstrm_crc_valid, dstrm_valid} = '0;
    // Quiet receive lanes through reset
    use_drv = 1'b1;
    for (int l = 0; l < lane_cnt; l++) begin
      rx_drv[l]   = '0;
      m_tx_phy[l] = '0;
    end
    {m_rx_flit, m_ustrm, cur_flit, m_rx_ok, m_tx_od, m_rx_od} = '0;
    m_tx_run = 0;
    m_rx_run = 0;

    //       name           tx rx bad dx dy cyc st   pid dv crc  cv v
    add_row("reset_idle",   0, 0, 0,  3, 5, 4,  4'h1, 1, 1, 4'hA, 1, 1);
    add_row("tx_delay",     1, 0, 0,  3, 5, 8,  4'h2, 1, 0, 4'h3, 1, 1);
    add_row("rx_align",     1, 1, 0,  3, 5, 6,  4'h3, 2, 1, 4'h5, 1, 1);
    add_row("loopback",     1, 1, 0,  3, 5, 16, 4'h4, 3, 1, 4'h9, 1, 1);
    add_row("lane_map",     1, 1, 0,  3, 5, 4,  4'hF, 0, 0, 4'hC, 0, 1);
    add_row("strobe_loss",  1, 1, 1,  3, 5, 5,  4'h5, 1, 1, 4'h6, 1, 1);
    add_row("recover",      1, 1, 0,  3, 5, 4,  4'h6, 2, 1, 4'h7, 1, 1);
    add_row("rx_offline",   1, 0, 0,  3, 5, 5,  4'h7, 3, 1, 4'h8, 1, 1);
    add_row("tx_offline",   0, 0, 0,  3, 5, 3,  4'h0, 0, 0, 4'h0, 0, 0);
    add_row("zero_delay",   1, 1, 0,  0, 0, 6,  4'h8, 1, 1, 4'h2, 1, 1);

    limit = n_rows * max_delay + 50;
    for (int r = 0; r < n_rows; r++)
      limit += row_tab[r].cycles;

    @(posedge rst_n);
    check_outputs("reset");
    for (int r = 0; r < n_rows; r++) begin
      for (int c = 0; c < row_tab[r].cycles; c++) begin
        drive_row(r, c);
        @(posedge clk_wr);
        @(negedge clk_wr);
        step_model();
        check_outputs(row_name[r]);
      end
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== flist.f ====
source/lpif_link_pkg.sv
source/lpif_online_sync.sv
source/lpif_flit_map.sv
source/lpif_lane_stripe.sv
source/lpif_link_top.sv
tb/tb_clock_gen.sv
tb/lpif_link_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the LPIF logic link

TOP := lpif_link_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module lpif_link_top

clean:
	rm -rf obj_dir
